/* common/csr_addr_pkg.sv */
`default_nettype none

package csr_addr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam int CSR_DATA_W = 32;

    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

    // software-writable bits
    localparam logic [CSR_DATA_W-1:0] CRMD_WMASK   = 32'h0000_01ff;
    localparam logic [CSR_DATA_W-1:0] PRMD_WMASK   = 32'h0000_0007;
    localparam logic [CSR_DATA_W-1:0] ECFG_WMASK   = 32'h0000_1bff; // bit 10 reserved
    localparam logic [CSR_DATA_W-1:0] ESTAT_WMASK  = 32'h0000_0003; // soft irq only
    localparam logic [CSR_DATA_W-1:0] EENTRY_WMASK = 32'hffff_ffc0;

    // field positions, prmd shares the crmd layout for plv/ie
    localparam int CRMD_PLV_LSB      = 0;
    localparam int CRMD_IE_BIT       = 2;
    localparam int ESTAT_HWI_LSB     = 2;
    localparam int ESTAT_TI_BIT      = 11;
    localparam int ESTAT_ECODE_LSB   = 16;
    localparam int ESTAT_ESUB_LSB    = 22;
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int INT_LINES         = 13;

    localparam logic [CSR_DATA_W-1:0] CRMD_RESET = 32'h0000_0008; // da set

    localparam int HWI_W = 8;

endpackage

`default_nettype wire

/* common/csr_excp_pkg.sv */
`default_nettype none

package csr_excp_pkg;

    // cause as reported by the pipeline control
    typedef enum logic [6:0] {
        EXC_INT  = 7'h00,
        EXC_ADEF = 7'h08,  // fetch address error
        EXC_ALE  = 7'h09,  // misaligned load/store
        EXC_SYS  = 7'h0b,
        EXC_BRK  = 7'h0c,
        EXC_INE  = 7'h0d
    } excp_cause_e;

    localparam int ECODE_W = 6;
    localparam int ESUB_W  = 9;

endpackage

`default_nettype wire

/* hdl/csr_read_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_read_mux
    import csr_addr_pkg::*;
(
    input  wire [1:0]             read_en_i,
    input  wire csr_addr_e        read_addr0_i,
    input  wire csr_addr_e        read_addr1_i,
    input  wire [CSR_DATA_W-1:0]  crmd_i,
    input  wire [CSR_DATA_W-1:0]  prmd_i,
    input  wire [CSR_DATA_W-1:0]  ecfg_i,
    input  wire [CSR_DATA_W-1:0]  estat_i,
    input  wire [CSR_DATA_W-1:0]  era_i,
    input  wire [CSR_DATA_W-1:0]  badv_i,
    input  wire [CSR_DATA_W-1:0]  eentry_i,
    input  wire [CSR_DATA_W-1:0]  save0_i,
    input  wire [CSR_DATA_W-1:0]  save1_i,
    input  wire [CSR_DATA_W-1:0]  save2_i,
    input  wire [CSR_DATA_W-1:0]  save3_i,
    input  wire [CSR_DATA_W-1:0]  tcfg_i,
    input  wire [CSR_DATA_W-1:0]  tval_i,
    output logic [CSR_DATA_W-1:0] read_data0_o,
    output logic [CSR_DATA_W-1:0] read_data1_o
);

    // shared by both ports
    function automatic logic [CSR_DATA_W-1:0] sel_reg(input logic en, input csr_addr_e addr);
        logic [CSR_DATA_W-1:0] val;
        val = '0;
        if (en) begin
            case (addr)
                CSR_CRMD:   val = crmd_i;
                CSR_PRMD:   val = prmd_i;
                CSR_ECFG:   val = ecfg_i;
                CSR_ESTAT:  val = estat_i;
                CSR_ERA:    val = era_i;
                CSR_BADV:   val = badv_i;
                CSR_EENTRY: val = eentry_i;
                CSR_SAVE0:  val = save0_i;
                CSR_SAVE1:  val = save1_i;
                CSR_SAVE2:  val = save2_i;
                CSR_SAVE3:  val = save3_i;
                CSR_TCFG:   val = tcfg_i;
                CSR_TVAL:   val = tval_i;
                default:    val = '0;  // ticlr and unknown
            endcase
        end
        return val;
    endfunction

    always_comb begin
        read_data0_o = sel_reg(read_en_i[0], read_addr0_i);
        read_data1_o = sel_reg(read_en_i[1], read_addr1_i);
    end

endmodule

`default_nettype wire

/* hdl/csr_top.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_top
    import csr_addr_pkg::*, csr_excp_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire [1:0]             read_en_i,
    input  wire csr_addr_e        read_addr0_i,
    input  wire csr_addr_e        read_addr1_i,
    input  wire                   write_en_i,
    input  wire csr_addr_e        write_addr_i,
    input  wire [CSR_DATA_W-1:0]  write_data_i,
    input  wire [HWI_W-1:0]       hwi_i,
    input  wire                   exception_i,
    input  wire excp_cause_e      exception_cause_i,
    input  wire [CSR_DATA_W-1:0]  exception_pc_i,
    input  wire [CSR_DATA_W-1:0]  exception_addr_i,
    input  wire [ECODE_W-1:0]     ecode_i,
    input  wire [ESUB_W-1:0]      esubcode_i,
    input  wire                   ertn_i,
    output logic [CSR_DATA_W-1:0] read_data0_o,
    output logic [CSR_DATA_W-1:0] read_data1_o,
    output logic [CSR_DATA_W-1:0] crmd_o,
    output logic [CSR_DATA_W-1:0] era_o,
    output logic [CSR_DATA_W-1:0] eentry_o,
    output logic                  interrupt_o
);

    logic                  crmd_we, prmd_we, ecfg_we, estat_we;
    logic                  era_we, badv_we, eentry_we;
    logic [3:0]            save_we;
    logic                  tcfg_we, ticlr_we;
    logic                  timer_irq;
    logic [CSR_DATA_W-1:0] crmd, prmd, ecfg, estat, era, badv, eentry;
    logic [CSR_DATA_W-1:0] save0, save1, save2, save3;
    logic [CSR_DATA_W-1:0] tcfg, tval;

    csr_write_decode u_decode (
        .write_en_i   (write_en_i),   .write_addr_i (write_addr_i),
        .crmd_we_o    (crmd_we),      .prmd_we_o    (prmd_we),
        .ecfg_we_o    (ecfg_we),      .estat_we_o   (estat_we),
        .era_we_o     (era_we),       .badv_we_o    (badv_we),
        .eentry_we_o  (eentry_we),    .save_we_o    (save_we),
        .tcfg_we_o    (tcfg_we),      .ticlr_we_o   (ticlr_we)
    );

    csr_trap_regs u_trap (
        .clk (clk), .rst (rst),
        .crmd_we_i (crmd_we), .prmd_we_i (prmd_we), .ecfg_we_i (ecfg_we),
        .estat_we_i (estat_we), .era_we_i (era_we), .badv_we_i (badv_we),
        .eentry_we_i (eentry_we), .save_we_i (save_we), .write_data_i (write_data_i),
        .exception_i (exception_i), .exception_cause_i (exception_cause_i),
        .exception_pc_i (exception_pc_i), .exception_addr_i (exception_addr_i),
        .ecode_i (ecode_i), .esubcode_i (esubcode_i), .ertn_i (ertn_i),
        .hwi_i (hwi_i), .timer_irq_i (timer_irq), .ticlr_we_i (ticlr_we),
        .crmd_o (crmd), .prmd_o (prmd), .ecfg_o (ecfg), .estat_o (estat),
        .era_o (era), .badv_o (badv), .eentry_o (eentry),
        .save0_o (save0), .save1_o (save1), .save2_o (save2), .save3_o (save3),
        .interrupt_o (interrupt_o)
    );

    csr_timer u_timer (
        .clk (clk), .rst (rst),
        .tcfg_we_i (tcfg_we), .write_data_i (write_data_i),
        .tcfg_o (tcfg), .tval_o (tval), .timer_irq_o (timer_irq)
    );

    csr_read_mux u_rdmux (
        .read_en_i (read_en_i), .read_addr0_i (read_addr0_i), .read_addr1_i (read_addr1_i),
        .crmd_i (crmd), .prmd_i (prmd), .ecfg_i (ecfg), .estat_i (estat),
        .era_i (era), .badv_i (badv), .eentry_i (eentry),
        .save0_i (save0), .save1_i (save1), .save2_i (save2), .save3_i (save3),
        .tcfg_i (tcfg), .tval_i (tval),
        .read_data0_o (read_data0_o), .read_data1_o (read_data1_o)
    );

    assign crmd_o   = crmd;
    assign era_o    = era;
    assign eentry_o = eentry;

endmodule

`default_nettype wire

/* hdl/csr_write_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_write_decode
    import csr_addr_pkg::*;
(
    input  wire       write_en_i,
    input  wire       csr_addr_e write_addr_i,
    output logic      crmd_we_o,
    output logic      prmd_we_o,
    output logic      ecfg_we_o,
    output logic      estat_we_o,
    output logic      era_we_o,
    output logic      badv_we_o,
    output logic      eentry_we_o,
    output logic [3:0] save_we_o,
    output logic      tcfg_we_o,
    output logic      ticlr_we_o
);

    always_comb begin
        crmd_we_o   = 1'b0;
        prmd_we_o   = 1'b0;
        ecfg_we_o   = 1'b0;
        estat_we_o  = 1'b0;
        era_we_o    = 1'b0;
        badv_we_o   = 1'b0;
        eentry_we_o = 1'b0;
        save_we_o   = 4'b0;
        tcfg_we_o   = 1'b0;
        ticlr_we_o  = 1'b0;
        if (write_en_i) begin
            case (write_addr_i)
                CSR_CRMD:   crmd_we_o    = 1'b1;
                CSR_PRMD:   prmd_we_o    = 1'b1;
                CSR_ECFG:   ecfg_we_o    = 1'b1;
                CSR_ESTAT:  estat_we_o   = 1'b1;
                CSR_ERA:    era_we_o     = 1'b1;
                CSR_BADV:   badv_we_o    = 1'b1;
                CSR_EENTRY: eentry_we_o  = 1'b1;
                CSR_SAVE0:  save_we_o[0] = 1'b1;
                CSR_SAVE1:  save_we_o[1] = 1'b1;
                CSR_SAVE2:  save_we_o[2] = 1'b1;
                CSR_SAVE3:  save_we_o[3] = 1'b1;
                CSR_TCFG:   tcfg_we_o    = 1'b1;
                CSR_TICLR:  ticlr_we_o   = 1'b1;
                default: ; // tval is read-only
            endcase
        end
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+test
common/csr_addr_pkg.sv
common/csr_excp_pkg.sv
hdl/csr_write_decode.sv
trap/csr_trap_regs.sv
trap/csr_timer.sv
hdl/csr_read_mux.sv
hdl/csr_top.sv
test/csr_tb.sv

/* run.sh */
#!/bin/bash
# build the csr testbench with verilator, run it, then search the log for the pass line

rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module csr_tb -o csr_sim -f list.f \
    && ./obj_dir/csr_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "^Done: no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* test/csr_tb_table.svh */
// columns: op, address or cause, data / pc / hwi / idle cycles, bad address or crmd data,
// ecode, esubcode, read enables, read addresses, expected reads, interrupt, random save data
task automatic load_table();
    // reset values
    add_row(OP_READ,  14'h0,         32'h0,         32'h0,         6'h00, 9'h000,
            2'b11, CSR_CRMD,   CSR_ERA,    32'h0000_0008, 32'h0000_0000, 1'b0, 1'b0);
    add_row(OP_READ,  14'h0,         32'h0,         32'h0,         6'h00, 9'h000,
            2'b11, CSR_ESTAT,  CSR_SAVE0,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
    add_row(OP_READ,  14'h0,         32'h0,         32'h0,         6'h00, 9'h000,
            2'b11, CSR_TVAL,   CSR_TVAL,   32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
    // all-ones writes read back the masks
    add_row(OP_WRITE, CSR_CRMD,      32'hffff_ffff, 32'h0,         6'h00, 9'h000,
            2'b11, CSR_CRMD,   CSR_PRMD,   32'h0000_01ff, 32'h0000_0000, 1'b0, 1'b0);
    add_row(OP_WRITE, CSR_PRMD,      32'hffff_ffff, 32'h0,         6'h00, 9'h000,
            2'b11, CSR_PRMD,   CSR_CRMD,   32'h0000_0007, 32'h0000_01ff, 1'b0, 1'b0);
    add_row(OP_WRITE, CSR_ECFG,      32'hffff_ffff, 32'h0,         6'h00, 9'h000,
            2'b11, CSR_ECFG,   CSR_ESTAT,  32'h0000_1bff, 32'h0000_0000, 1'b0, 1'b0);
    add_row(OP_WRITE, CSR_EENTRY,    32'hffff_ffff, 32'h0,         6'h00, 9'h000,
            2'b11, CSR_EENTRY, CSR_ECFG,   32'hffff_ffc0, 32'h0000_1bff, 1'b0, 1'b0);
    add_row(OP_WRITE, CSR_SAVE0,     32'h0,         32'h0,         6'h00, 9'h000,
            2'b11, CSR_SAVE0,  CSR_SAVE1,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1);
    add_row(OP_WRITE, CSR_SAVE1,     32'h0,         32'h0,         6'h00, 9'h000,
            2'b11, CSR_SAVE1,  CSR_SAVE0,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1);
    add_row(OP_WRITE, CSR_SAVE2,     32'h0,         32'h0,         6'h00, 9'h000,
            2'b11, CSR_SAVE2,  CSR_SAVE3,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1);
    add_row(OP_WRITE, CSR_SAVE3,     32'h0,         32'h0,         6'h00, 9'h000,
            2'b11, CSR_SAVE3,  CSR_SAVE2,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1);
    add_row(OP_READ,  14'h0,         32'h0,         32'h0,         6'h00, 9'h000,
            2'b10, CSR_CRMD,   CSR_SAVE1,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1);
    add_row(OP_READ,  14'h0,         32'h0,         32'h0,         6'h00, 9'h000,
            2'b11, 14'h3ff,    CSR_TICLR,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
    add_row(OP_WRITE, CSR_ESTAT,     32'hffff_ffff, 32'h0,         6'h00, 9'h000,
            2'b11, CSR_ESTAT,  CSR_ECFG,   32'h0000_0003, 32'h0000_1bff, 1'b1, 1'b0);
    add_row(OP_WRITE, CSR_ESTAT,     32'h0,         32'h0,         6'h00, 9'h000,
            2'b11, CSR_ESTAT,  CSR_CRMD,   32'h0000_0000, 32'h0000_01ff, 1'b0, 1'b0);
    // exception entry from plv 3 with ie set
    add_row(OP_WRITE, CSR_PRMD,      32'h0,         32'h0,         6'h00, 9'h000,
            2'b11, CSR_PRMD,   CSR_ECFG,   32'h0000_0000, 32'h0000_1bff, 1'b0, 1'b0);
    add_row(OP_EXC,   14'(EXC_ALE),  32'h1c00_0100, 32'h0000_0123, 6'h09, 9'h005,
            2'b11, CSR_CRMD,   CSR_PRMD,   32'h0000_01f8, 32'h0000_0007, 1'b0, 1'b0);
    add_row(OP_READ,  14'h0,         32'h0,         32'h0,         6'h00, 9'h000,
            2'b11, CSR_ERA,    CSR_BADV,   32'h1c00_0100, 32'h0000_0123, 1'b0, 1'b0);
    add_row(OP_READ,  14'h0,         32'h0,         32'h0,         6'h00, 9'h000,
            2'b11, CSR_ESTAT,  CSR_CRMD,   32'h0149_0000, 32'h0000_01f8, 1'b0, 1'b0);
    add_row(OP_EXC,   14'(EXC_ADEF), 32'h1c00_0200, 32'hdead_beef, 6'h08, 9'h000,
            2'b11, CSR_BADV,   CSR_ERA,    32'h1c00_0200, 32'h1c00_0200, 1'b0, 1'b0);
    add_row(OP_EXC,   14'(EXC_SYS),  32'h1c00_0300, 32'h0bad_0bad, 6'h0b, 9'h000,
            2'b11, CSR_BADV,   CSR_ESTAT,  32'h1c00_0200, 32'h000b_0000, 1'b0, 1'b0);
    // return restores plv 1 with ie
    add_row(OP_WRITE, CSR_PRMD,      32'h0000_0005, 32'h0,         6'h00, 9'h000,
            2'b11, CSR_PRMD,   CSR_CRMD,   32'h0000_0005, 32'h0000_01f8, 1'b0, 1'b0);
    add_row(OP_ERTN,  14'h0,         32'h0,         32'h0,         6'h00, 9'h000,
            2'b11, CSR_CRMD,   CSR_PRMD,   32'h0000_01fd, 32'h0000_0005, 1'b0, 1'b0);
    add_row(OP_EXCW,  14'(EXC_SYS),  32'h1c00_0400, 32'h0000_0007, 6'h0b, 9'h000,
            2'b11, CSR_CRMD,   CSR_PRMD,   32'h0000_01f8, 32'h0000_0005, 1'b0, 1'b0);
    add_row(OP_ERTN,  14'h0,         32'h0,         32'h0,         6'h00, 9'h000,
            2'b11, CSR_CRMD,   CSR_ERA,    32'h0000_01fd, 32'h1c00_0400, 1'b0, 1'b0);
    // one-shot timer, initial value 0x10
    add_row(OP_WRITE, CSR_TCFG,      32'h0000_0011, 32'h0,         6'h00, 9'h000,
            2'b11, CSR_TVAL,   CSR_TCFG,   32'h0000_0010, 32'h0000_0011, 1'b0, 1'b0);
    add_row(OP_READ,  14'h0,         32'h0,         32'h0,         6'h00, 9'h000,
            2'b11, CSR_TVAL,   CSR_TCFG,   32'h0000_000f, 32'h0000_0011, 1'b0, 1'b0);
    add_row(OP_IDLE,  14'h0,         32'd3,         32'h0,         6'h00, 9'h000,
            2'b11, CSR_TVAL,   CSR_TCFG,   32'h0000_000c, 32'h0000_0011, 1'b0, 1'b0);
    add_row(OP_IDLE,  14'h0,         32'd16,        32'h0,         6'h00, 9'h000,
            2'b11, CSR_ESTAT,  CSR_TVAL,   32'h000b_0800, 32'h0000_0000, 1'b1, 1'b0);
    add_row(OP_WRITE, CSR_TICLR,     32'h0000_0001, 32'h0,         6'h00, 9'h000,
            2'b11, CSR_ESTAT,  CSR_TVAL,   32'h000b_0000, 32'h0000_0000, 1'b0, 1'b0);
    // hardware lines land in bits 9:2
    add_row(OP_HWI,   14'h0,         32'h0000_00a5, 32'h0,         6'h00, 9'h000,
            2'b11, CSR_ESTAT,  CSR_ECFG,   32'h000b_0294, 32'h0000_1bff, 1'b1, 1'b0);
    add_row(OP_WRITE, CSR_ECFG,      32'h0000_0800, 32'h0,         6'h00, 9'h000,
            2'b11, CSR_ECFG,   CSR_ESTAT,  32'h0000_0800, 32'h000b_0294, 1'b0, 1'b0);
    add_row(OP_WRITE, CSR_ECFG,      32'h0000_0104, 32'h0,         6'h00, 9'h000,
            2'b11, CSR_ECFG,   CSR_ESTAT,  32'h0000_0104, 32'h000b_0294, 1'b1, 1'b0);
    add_row(OP_WRITE, CSR_CRMD,      32'h0,         32'h0,         6'h00, 9'h000,
            2'b11, CSR_CRMD,   CSR_ESTAT,  32'h0000_0000, 32'h000b_0294, 1'b0, 1'b0);
    add_row(OP_HWI,   14'h0,         32'h0,         32'h0,         6'h00, 9'h000,
            2'b11, CSR_ESTAT,  CSR_ECFG,   32'h000b_0000, 32'h0000_0104, 1'b0, 1'b0);
endtask

/* test/csr_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_tb
    import csr_addr_pkg::*, csr_excp_pkg::*;
();

    // excw is an exception with a crmd write in the same cycle
    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_EXC, OP_EXCW, OP_ERTN, OP_HWI, OP_IDLE} op_e;

    typedef struct packed {
        op_e         op;
        logic [13:0] sel;
        logic [31:0] data;
        logic [31:0] aux;
        logic [5:0]  ec;
        logic [8:0]  es;
        logic [1:0]  ren;
        logic [13:0] ra0;
        logic [13:0] ra1;
        logic [31:0] exp0;
        logic [31:0] exp1;
        logic        exp_int;
        logic        rnd;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic [1:0]            read_en;
    csr_addr_e             read_addr0, read_addr1, write_addr;
    logic                  write_en;
    logic [CSR_DATA_W-1:0] write_data;
    logic [HWI_W-1:0]      hwi;
    logic                  exception, ertn;
    excp_cause_e           exc_cause;
    logic [CSR_DATA_W-1:0] exc_pc, exc_addr;
    logic [ECODE_W-1:0]    ecode;
    logic [ESUB_W-1:0]     esub;
    logic [CSR_DATA_W-1:0] read_data0, read_data1, crmd, era, eentry;
    logic                  interrupt;

    row_t                  tbl [$];
    logic [CSR_DATA_W-1:0] save_model [4];
    integer                seed = 32'hb72413ad;
    int                    errors;
    int                    checks;

    csr_top dut0 (
        .clk (clk), .rst (rst),
        .read_en_i (read_en), .read_addr0_i (read_addr0), .read_addr1_i (read_addr1),
        .write_en_i (write_en), .write_addr_i (write_addr), .write_data_i (write_data),
        .hwi_i (hwi), .exception_i (exception), .exception_cause_i (exc_cause),
        .exception_pc_i (exc_pc), .exception_addr_i (exc_addr),
        .ecode_i (ecode), .esubcode_i (esub), .ertn_i (ertn),
        .read_data0_o (read_data0), .read_data1_o (read_data1),
        .crmd_o (crmd), .era_o (era), .eentry_o (eentry), .interrupt_o (interrupt)
    );

    always #10 clk = ~clk;

    task automatic add_row(input op_e op, input logic [13:0] sel, input logic [31:0] data,
                           input logic [31:0] aux, input logic [5:0] ec, input logic [8:0] es,
                           input logic [1:0] ren, input logic [13:0] ra0,
                           input logic [13:0] ra1, input logic [31:0] exp0,
                           input logic [31:0] exp1, input logic exp_int, input logic rnd);
        row_t r;
        r = {op, sel, data, aux, ec, es, ren, ra0, ra1, exp0, exp1, exp_int, rnd};
        tbl.push_back(r);
    endtask

    `include "csr_tb_table.svh"

    task automatic apply_row(input row_t r);
        logic [CSR_DATA_W-1:0] wdata;
        wdata = r.data;
        if (r.op == OP_WRITE && r.rnd)
            wdata = $random(seed);
        write_en   = (r.op == OP_WRITE) || (r.op == OP_EXCW);
        write_addr = (r.op == OP_EXCW) ? CSR_CRMD : csr_addr_e'(r.sel);
        write_data = (r.op == OP_EXCW) ? r.aux : wdata;
        exception  = (r.op == OP_EXC) || (r.op == OP_EXCW);
        exc_cause  = excp_cause_e'(r.sel[6:0]);
        exc_pc     = r.data;
        exc_addr   = r.aux;
        ecode      = r.ec;
        esub       = r.es;
        ertn       = (r.op == OP_ERTN);
        if (r.op == OP_HWI)
            hwi = r.data[HWI_W-1:0];  // held until the next hwi row
        read_en    = r.ren;
        read_addr0 = csr_addr_e'(r.ra0);
        read_addr1 = csr_addr_e'(r.ra1);
        if (r.op == OP_WRITE && r.sel[13:2] == 12'h00c)
            save_model[r.sel[1:0]] = wdata;
    endtask

    // save registers hold random data, so their value comes from the model
    function automatic logic [CSR_DATA_W-1:0] expect_port(input logic en, input logic rnd,
                                                          input logic [13:0] addr,
                                                          input logic [31:0] tab);
        if (en && rnd && addr[13:2] == 12'h00c)
            return save_model[addr[1:0]];
        return tab;
    endfunction

    task automatic compare_out(input string name, input int row,
                               input logic [31:0] want, input logic [31:0] got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("** Error at %0d ns: %s (row %0d) expected %h, got %h",
                     $time, name, row, want, got);
        end
    endtask

    // direct outputs match the register that an enabled port reads
    task automatic check_direct(input logic en, input logic [13:0] addr,
                                input logic [31:0] want, input int row);
        if (en && addr == CSR_CRMD)
            compare_out("crmd_o", row, want, crmd);
        if (en && addr == CSR_ERA)
            compare_out("era_o", row, want, era);
        if (en && addr == CSR_EENTRY)
            compare_out("eentry_o", row, want, eentry);
    endtask

    initial begin
        int                    cycles;
        logic [CSR_DATA_W-1:0] want0;
        logic [CSR_DATA_W-1:0] want1;
        clk        = 1'b0;
        rst        = 1'b1;
        read_en    = 2'b00;
        read_addr0 = CSR_CRMD;
        read_addr1 = CSR_CRMD;
        write_en   = 1'b0;
        write_addr = CSR_CRMD;
        write_data = '0;
        hwi        = '0;
        exception  = 1'b0;
        exc_cause  = EXC_INT;
        exc_pc     = '0;
        exc_addr   = '0;
        ecode      = '0;
        esub       = '0;
        ertn       = 1'b0;
        errors     = 0;
        checks     = 0;
        for (int k = 0; k < 4; k++)
            save_model[k] = '0;
        load_table();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        foreach (tbl[i]) begin
            apply_row(tbl[i]);
            cycles = (tbl[i].op == OP_IDLE) ? int'(tbl[i].data) : 1;
            repeat (cycles) @(negedge clk);
            want0 = expect_port(tbl[i].ren[0], tbl[i].rnd, tbl[i].ra0, tbl[i].exp0);
            want1 = expect_port(tbl[i].ren[1], tbl[i].rnd, tbl[i].ra1, tbl[i].exp1);
            checks += 3;
            if (read_data0 !== want0) begin
                errors++;
                $display("** Error at %0d ns: read_data0_o (row %0d) expected %h, got %h",
                         $time, i, want0, read_data0);
            end
            if (read_data1 !== want1) begin
                errors++;
                $display("** Error at %0d ns: read_data1_o (row %0d) expected %h, got %h",
                         $time, i, want1, read_data1);
            end
            if (interrupt !== tbl[i].exp_int) begin
                errors++;
                $display("** Error at %0d ns: interrupt_o (row %0d) expected %b, got %b",
                         $time, i, tbl[i].exp_int, interrupt);
            end
            check_direct(tbl[i].ren[0], tbl[i].ra0, want0, i);
            check_direct(tbl[i].ren[1], tbl[i].ra1, want1, i);
        end
        $display("csr_tb: %0d errors in %0d checks over %0d rows", errors, checks, tbl.size());
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // limit in cycles, from the table length plus margin
    initial begin
        int limit;
        #1;
        limit = tbl.size() + 20;
        foreach (tbl[i]) begin
            if (tbl[i].op == OP_IDLE)
                limit += int'(tbl[i].data);
        end
        #(limit * 20);
        $display("timeout: the table did not finish within %0d clock cycles", limit);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* trap/csr_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_timer
    import csr_addr_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   tcfg_we_i,
    input  wire [CSR_DATA_W-1:0]  write_data_i,
    output logic [CSR_DATA_W-1:0] tcfg_o,
    output logic [CSR_DATA_W-1:0] tval_o,
    output logic                  timer_irq_o
);

    logic [CSR_DATA_W-1:0] tcfg;
    logic [CSR_DATA_W-1:0] tval;
    logic                  timer_en;
    logic                  expired;

    assign expired = timer_en && (tval == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg     <= '0;
            timer_en <= 1'b0;
        end else if (tcfg_we_i) begin
            tcfg     <= write_data_i;
            timer_en <= write_data_i[TCFG_EN_BIT];
        end else if (expired && !tcfg[TCFG_PERIODIC_BIT]) begin
            timer_en <= 1'b0;  // one-shot stops
        end
    end

    // initial value is tcfg with en/periodic bits masked off
    always_ff @(posedge clk) begin
        if (rst) begin
            tval <= '0;
        end else if (tcfg_we_i) begin
            tval <= {write_data_i[CSR_DATA_W-1:2], 2'b00};
        end else if (timer_en) begin
            if (tval != '0)
                tval <= tval - 1'b1;
            else if (tcfg[TCFG_PERIODIC_BIT])
                tval <= {tcfg[CSR_DATA_W-1:2], 2'b00}; // reload
        end
    end

    assign timer_irq_o = expired;  // one cycle, en drops or tval reloads
    assign tcfg_o      = tcfg;
    assign tval_o      = tval;

endmodule

`default_nettype wire

/* trap/csr_trap_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_trap_regs
    import csr_addr_pkg::*, csr_excp_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   crmd_we_i,
    input  wire                   prmd_we_i,
    input  wire                   ecfg_we_i,
    input  wire                   estat_we_i,
    input  wire                   era_we_i,
    input  wire                   badv_we_i,
    input  wire                   eentry_we_i,
    input  wire [3:0]             save_we_i,
    input  wire [CSR_DATA_W-1:0]  write_data_i,
    input  wire                   exception_i,
    input  wire excp_cause_e      exception_cause_i,
    input  wire [CSR_DATA_W-1:0]  exception_pc_i,
    input  wire [CSR_DATA_W-1:0]  exception_addr_i,
    input  wire [ECODE_W-1:0]     ecode_i,
    input  wire [ESUB_W-1:0]      esubcode_i,
    input  wire                   ertn_i,
    input  wire [HWI_W-1:0]       hwi_i,
    input  wire                   timer_irq_i,
    input  wire                   ticlr_we_i,
    output logic [CSR_DATA_W-1:0] crmd_o,
    output logic [CSR_DATA_W-1:0] prmd_o,
    output logic [CSR_DATA_W-1:0] ecfg_o,
    output logic [CSR_DATA_W-1:0] estat_o,
    output logic [CSR_DATA_W-1:0] era_o,
    output logic [CSR_DATA_W-1:0] badv_o,
    output logic [CSR_DATA_W-1:0] eentry_o,
    output logic [CSR_DATA_W-1:0] save0_o,
    output logic [CSR_DATA_W-1:0] save1_o,
    output logic [CSR_DATA_W-1:0] save2_o,
    output logic [CSR_DATA_W-1:0] save3_o,
    output logic                  interrupt_o
);

    logic [CSR_DATA_W-1:0] crmd;
    logic [CSR_DATA_W-1:0] prmd;
    logic [CSR_DATA_W-1:0] ecfg;
    logic [CSR_DATA_W-1:0] estat;
    logic [CSR_DATA_W-1:0] estat_d;
    logic [CSR_DATA_W-1:0] era;
    logic [CSR_DATA_W-1:0] badv;
    logic [CSR_DATA_W-1:0] eentry;
    logic [CSR_DATA_W-1:0] save_q [4];

    function automatic logic [CSR_DATA_W-1:0] wmerge(
        input logic [CSR_DATA_W-1:0] cur,
        input logic [CSR_DATA_W-1:0] wdata,
        input logic [CSR_DATA_W-1:0] mask
    );
        return (cur & ~mask) | (wdata & mask);
    endfunction

    // exception > ertn > write
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd <= CRMD_RESET;
        end else if (exception_i) begin
            crmd[CRMD_PLV_LSB +: 2] <= 2'b0;
            crmd[CRMD_IE_BIT]       <= 1'b0;
        end else if (ertn_i) begin
            crmd[CRMD_PLV_LSB +: 2] <= prmd[CRMD_PLV_LSB +: 2];
            crmd[CRMD_IE_BIT]       <= prmd[CRMD_IE_BIT];
        end else if (crmd_we_i) begin
            crmd <= wmerge(crmd, write_data_i, CRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd <= '0;
        end else if (exception_i) begin
            prmd[CRMD_PLV_LSB +: 2] <= crmd[CRMD_PLV_LSB +: 2]; // pplv
            prmd[CRMD_IE_BIT]       <= crmd[CRMD_IE_BIT];       // pie
        end else if (prmd_we_i) begin
            prmd <= wmerge(prmd, write_data_i, PRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg   <= '0;
            eentry <= '0;
        end else begin
            if (ecfg_we_i)
                ecfg <= wmerge(ecfg, write_data_i, ECFG_WMASK);
            if (eentry_we_i)
                eentry <= wmerge(eentry, write_data_i, EENTRY_WMASK);
        end
    end

    always_comb begin
        estat_d = estat;
        estat_d[ESTAT_HWI_LSB +: HWI_W] = hwi_i; // sampled every cycle
        if (ticlr_we_i && write_data_i[0])
            estat_d[ESTAT_TI_BIT] = 1'b0;  // clear beats expiry
        else if (timer_irq_i)
            estat_d[ESTAT_TI_BIT] = 1'b1;
        if (exception_i) begin
            estat_d[ESTAT_ECODE_LSB +: ECODE_W] = ecode_i;
            estat_d[ESTAT_ESUB_LSB +: ESUB_W]   = esubcode_i;
        end else if (estat_we_i) begin
            estat_d = wmerge(estat_d, write_data_i, ESTAT_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            estat <= '0;
        else
            estat <= estat_d;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            era  <= '0;
            badv <= '0;
        end else if (exception_i) begin
            era <= exception_pc_i;
            case (exception_cause_i)
                EXC_ALE:  badv <= exception_addr_i;
                EXC_ADEF: badv <= exception_pc_i;
                default: ;
            endcase
        end else begin
            if (era_we_i)
                era <= write_data_i;
            if (badv_we_i)
                badv <= write_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++)
                save_q[i] <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (save_we_i[i])
                    save_q[i] <= write_data_i;
            end
        end
    end

    assign interrupt_o = (|(ecfg[INT_LINES-1:0] & estat[INT_LINES-1:0])) & crmd[CRMD_IE_BIT];

    assign crmd_o   = crmd;
    assign prmd_o   = prmd;
    assign ecfg_o   = ecfg;
    assign estat_o  = estat;
    assign era_o    = era;
    assign badv_o   = badv;
    assign eentry_o = eentry;
    assign save0_o  = save_q[0];
    assign save1_o  = save_q[1];
    assign save2_o  = save_q[2];
    assign save3_o  = save_q[3];

endmodule

`default_nettype wire
